//--- common/ddr_pkg.sv
`default_nettype none

package ddr_pkg;

	// transfer stages of the engine, in bus order
	typedef enum logic [4:0]
	{
		st_idle,
		st_cmd_pre,          // command preamble
		st_rnw_bit,
		st_seven_zeros,
		st_address,          // 7-bit dynamic address
		st_parity,           // command or data parity, see ack_open
		st_ack_pre,
		st_ack_wait,
		st_first_byte,
		st_second_byte,
		st_dummy_byte,       // zero fill for an odd byte count
		st_data_pre,         // continue/abort preamble
		st_abort_bit,
		st_crc_pre_first,
		st_crc_pre_second,
		st_crc_token,
		st_crc_value,
		st_error,
		st_restart,
		st_exit
	} ddr_state_e;

	// serializer modes, codes as the tx block decodes them
	typedef enum logic [3:0]
	{
		txm_special_pre = 4'd0,
		txm_address     = 4'd1,
		txm_one         = 4'd2,
		txm_seven_zeros = 4'd3,
		txm_parity      = 4'd4,
		txm_zero        = 4'd6,
		txm_byte        = 4'd7,
		txm_crc_token   = 4'd12,
		txm_crc_value   = 4'd13,
		txm_exit        = 4'd14,
		txm_restart     = 4'd15
	} tx_mode_e;

	// deserializer modes
	typedef enum logic [3:0]
	{
		rxm_preamble   = 4'd0,
		rxm_byte       = 4'd3,
		rxm_token_chk  = 4'd5,
		rxm_parity_chk = 4'd6,
		rxm_crc_chk    = 4'd7,
		rxm_error      = 4'd15
	} rx_mode_e;

	// per-transfer result reported to the register file
	typedef enum logic [3:0]
	{
		err_success     = 4'd0,
		err_crc         = 4'd1,
		err_parity      = 4'd2,
		err_frame       = 4'd3,
		err_nack        = 4'd5,
		err_short_read  = 4'd7,
		err_bus_aborted = 4'd9
	} err_type_e;

	typedef logic [11:0] regf_addr_t;   // register file word address
	typedef logic [4:0]  dev_index_t;   // index into the device table
	typedef logic [6:0]  target_addr_t; // dynamic address on the bus

	typedef struct packed
	{
		logic       rnw;             // 1 = read
		logic       toc;             // 1 = exit, 0 = restart
		logic       short_read_err;  // short read counts as an error
		dev_index_t dev_index;
	} xfer_cfg_s;

	typedef struct packed
	{
		logic tx_done;   // serializer finished its mode
		logic rx_done;   // deserializer finished its mode
		logic rx_pre;    // sampled preamble bit
		logic rx_error;  // token/parity/crc mismatch
		logic frm_last;  // frame counter on its last byte
	} phy_status_s;

	typedef struct packed
	{
		logic     tx_en;
		tx_mode_e tx_mode;
		logic     rx_en;
		rx_mode_e rx_mode;
		logic     frmcnt_en;
		logic     bitcnt_en;
		logic     bitcnt_rst;
	} phy_ctrl_s;

endpackage

`default_nettype wire

//--- source/ddr_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_sequencer
	import ddr_pkg::*;
(
	input  wire              i_sys_clk,
	input  wire              i_sys_rst,
	input  wire              i_engine_en,
	input  wire xfer_cfg_s   i_xfer_cfg,
	input  wire phy_status_s i_phy_status,
	output ddr_state_e       o_cur_state,
	output logic             o_ack_open,
	output logic             o_stage_done,
	output logic             o_regf_abort,
	output err_type_e        o_regf_error_type,
	output logic             o_engine_done
);

	ddr_state_e cur_state;
	ddr_state_e next_state;
	ddr_state_e end_state;   // restart or exit, per toc
	logic       rnw;
	logic       done;        // either side ended the stage
	logic       ack_open;    // past the ack and data phase still open
	logic       chk_fail;
	err_type_e  chk_code;
	err_type_e  err_q;
	logic       tgt_abort;

	assign rnw       = i_xfer_cfg.rnw;
	assign done      = i_phy_status.tx_done | i_phy_status.rx_done;
	assign end_state = i_xfer_cfg.toc ? st_exit : st_restart;

	// next stage and the checks that fail a transfer
	always_comb
	begin
		next_state = cur_state;
		chk_fail   = 1'b0;
		chk_code   = err_success;
		tgt_abort  = 1'b0;
		case (cur_state)
			st_idle        : if (i_engine_en) next_state = st_cmd_pre;
			st_cmd_pre     : if (done) next_state = st_rnw_bit;
			st_rnw_bit     : if (done) next_state = st_seven_zeros;
			st_seven_zeros : if (done) next_state = st_address;
			st_address     : if (done) next_state = st_parity;
			st_parity :
			begin
				if (done)
				begin
					if (!ack_open)
						next_state = st_ack_pre;          // command parity, ack comes next
					else if (!rnw)
						next_state = i_phy_status.frm_last ? st_crc_pre_first : st_data_pre;
					else if (i_phy_status.rx_error)
					begin
						next_state = st_error;            // read data parity mismatch
						chk_fail   = 1'b1;
						chk_code   = err_parity;
					end
					else
						next_state = st_data_pre;
				end
			end
			st_ack_pre     : if (done) next_state = st_ack_wait;
			st_ack_wait :
			begin
				if (i_phy_status.rx_done)
				begin
					if (i_phy_status.rx_pre)
					begin
						next_state = st_error;            // nack
						chk_fail   = 1'b1;
						chk_code   = err_nack;
					end
					else
						next_state = st_first_byte;
				end
			end
			st_first_byte :
			begin
				if (done)
					next_state = i_phy_status.frm_last ? st_dummy_byte : st_second_byte;
			end
			st_second_byte : if (done) next_state = st_parity;
			st_dummy_byte  : if (done) next_state = st_parity;
			st_data_pre :
			begin
				if (done)
				begin
					if (!rnw || i_phy_status.rx_pre)
						next_state = st_abort_bit;        // target wants to go on
					else if (!i_phy_status.frm_last && i_xfer_cfg.short_read_err)
					begin
						next_state = st_error;            // target stopped early
						chk_fail   = 1'b1;
						chk_code   = err_short_read;
					end
					else
						next_state = st_crc_pre_second;
				end
			end
			st_abort_bit :
			begin
				if (done)
				begin
					// write: target drives the bit, read: controller decides
					if (rnw ? i_phy_status.frm_last : !i_phy_status.rx_pre)
					begin
						next_state = st_error;
						chk_fail   = 1'b1;
						chk_code   = err_bus_aborted;
						tgt_abort  = !rnw;
					end
					else
						next_state = st_first_byte;
				end
			end
			st_crc_pre_first : if (done) next_state = st_crc_pre_second;
			st_crc_pre_second :
			begin
				if (done)
				begin
					if (rnw && !i_phy_status.rx_pre)
					begin
						next_state = st_error;            // 00 where the crc preamble belongs
						chk_fail   = 1'b1;
						chk_code   = err_frame;
					end
					else
						next_state = st_crc_token;
				end
			end
			st_crc_token :
			begin
				if (done)
				begin
					if (rnw && i_phy_status.rx_error)
					begin
						next_state = st_error;            // bad crc token
						chk_fail   = 1'b1;
						chk_code   = err_frame;
					end
					else
						next_state = st_crc_value;
				end
			end
			st_crc_value :
			begin
				if (done)
				begin
					if (rnw && i_phy_status.rx_error)
					begin
						next_state = st_error;
						chk_fail   = 1'b1;
						chk_code   = err_crc;
					end
					else
						next_state = end_state;
				end
			end
			st_error       : if (i_phy_status.rx_done) next_state = end_state;
			st_restart,
			st_exit        : if (i_phy_status.tx_done) next_state = st_idle;
			default        : next_state = st_idle;
		endcase
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			cur_state     <= st_idle;
			ack_open      <= 1'b0;
			err_q         <= err_success;
			o_regf_abort  <= 1'b0;
			o_engine_done <= 1'b0;
		end
		else
		begin
			cur_state <= next_state;
			// opens one cycle into ack_wait, closes when the controller ends a read
			if (cur_state == st_idle)
				ack_open <= 1'b0;
			else if (cur_state == st_ack_wait)
				ack_open <= 1'b1;
			else if (cur_state == st_data_pre && done && rnw && i_phy_status.frm_last)
				ack_open <= 1'b0;
			if (cur_state == st_idle && i_engine_en)
				err_q <= err_success;                 // new transfer
			else if (chk_fail && err_q == err_success)
				err_q <= chk_code;                    // first error wins
			o_regf_abort  <= tgt_abort;
			o_engine_done <= (cur_state == st_restart || cur_state == st_exit)
				&& i_phy_status.tx_done;
		end
	end

	assign o_cur_state       = cur_state;
	assign o_ack_open        = ack_open;
	assign o_stage_done      = done;
	assign o_regf_error_type = err_q;

endmodule

`default_nettype wire

//--- source/ddr_mode_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_mode_decode
	import ddr_pkg::*;
#(
	parameter target_addr_t ADDR_OFFSET = 7'd8
)
(
	input  wire ddr_state_e i_cur_state,
	input  wire             i_ack_open,
	input  wire xfer_cfg_s  i_xfer_cfg,
	output phy_ctrl_s       o_phy_ctrl,
	output logic [7:0]      o_tx_special_data
);

	phy_ctrl_s    ctrl;
	target_addr_t tgt_addr;
	logic         rnw;

	assign rnw      = i_xfer_cfg.rnw;
	assign tgt_addr = target_addr_t'(i_xfer_cfg.dev_index) + ADDR_OFFSET; // index 0 -> 8

	always_comb
	begin
		ctrl.tx_en        = 1'b0;
		ctrl.tx_mode      = txm_special_pre;
		ctrl.rx_en        = 1'b0;
		ctrl.rx_mode      = rxm_preamble;
		ctrl.frmcnt_en    = 1'b1;   // frame counter runs once the address is out
		ctrl.bitcnt_en    = 1'b1;
		ctrl.bitcnt_rst   = 1'b0;
		o_tx_special_data = 8'h00;
		case (i_cur_state)
			st_idle :
			begin
				ctrl.frmcnt_en = 1'b0;
				ctrl.bitcnt_en = 1'b0;
			end
			st_cmd_pre :
			begin
				ctrl.tx_en     = 1'b1;
				ctrl.frmcnt_en = 1'b0;
			end
			st_rnw_bit :
			begin
				ctrl.tx_en     = 1'b1;
				ctrl.tx_mode   = rnw ? txm_one : txm_zero;
				ctrl.frmcnt_en = 1'b0;
			end
			st_seven_zeros :
			begin
				ctrl.tx_en     = 1'b1;
				ctrl.tx_mode   = txm_seven_zeros;
				ctrl.frmcnt_en = 1'b0;
			end
			st_address :
			begin
				ctrl.tx_en        = 1'b1;
				ctrl.tx_mode      = txm_address;
				o_tx_special_data = {1'b0, tgt_addr};
			end
			st_parity :
			begin
				if (rnw && i_ack_open)
				begin
					ctrl.rx_en   = 1'b1;        // read data, target sent the parity
					ctrl.rx_mode = rxm_parity_chk;
				end
				else
				begin
					ctrl.tx_en   = 1'b1;
					ctrl.tx_mode = txm_parity;
				end
			end
			st_ack_pre :
			begin
				ctrl.tx_en   = 1'b1;
				ctrl.tx_mode = txm_one;
			end
			st_ack_wait :
			begin
				ctrl.rx_en = i_ack_open;    // one cycle late, bus turnaround
			end
			st_first_byte,
			st_second_byte,
			st_dummy_byte :
			begin
				ctrl.tx_en   = !rnw;
				ctrl.tx_mode = txm_byte;
				ctrl.rx_en   = rnw;
				ctrl.rx_mode = rxm_byte;
			end
			st_data_pre,
			st_crc_pre_second :
			begin
				ctrl.tx_en = !rnw;          // write: controller sends 1
				ctrl.tx_mode = txm_one;
				ctrl.rx_en = rnw;           // read: listen for the target
			end
			st_abort_bit :
			begin
				ctrl.tx_en   = rnw;
				ctrl.tx_mode = i_ack_open ? txm_one : txm_zero; // zero ends the read
				ctrl.rx_en   = !rnw;
			end
			st_crc_pre_first :
			begin
				ctrl.tx_en   = 1'b1;
				ctrl.tx_mode = txm_zero;
			end
			st_crc_token :
			begin
				ctrl.tx_en   = !rnw;
				ctrl.tx_mode = txm_crc_token;
				ctrl.rx_en   = rnw;
				ctrl.rx_mode = rxm_token_chk;
			end
			st_crc_value :
			begin
				ctrl.tx_en   = !rnw;
				ctrl.tx_mode = txm_crc_value;
				ctrl.rx_en   = rnw;
				ctrl.rx_mode = rxm_crc_chk;
			end
			st_error :
			begin
				ctrl.rx_en      = 1'b1;
				ctrl.rx_mode    = rxm_error;
				ctrl.bitcnt_rst = 1'b1;
			end
			st_restart,
			st_exit :
			begin
				ctrl.tx_en   = 1'b1;
				ctrl.tx_mode = (i_cur_state == st_exit) ? txm_exit : txm_restart;
			end
			default : ctrl.bitcnt_en = 1'b0;
		endcase
	end

	assign o_phy_ctrl = ctrl;

endmodule

`default_nettype wire

//--- source/regf_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module regf_addr_gen
	import ddr_pkg::*;
#(
	parameter regf_addr_t WR_BASE_ADDR = 12'd1,
	parameter regf_addr_t RD_BASE_ADDR = 12'd10,
	parameter regf_addr_t DUMMY_ADDR   = 12'd1000
)
(
	input  wire             i_sys_clk,
	input  wire             i_sys_rst,
	input  wire ddr_state_e i_cur_state,
	input  wire             i_ack_open,
	input  wire             i_stage_done,
	input  wire             i_rnw,
	output regf_addr_t      o_regf_addr,
	output logic            o_regf_rd_en,
	output logic            o_regf_wr_en
);

	regf_addr_t addr_q;      // running word address
	logic       in_data;     // a real data byte is on the bus
	logic       ack_end;

	assign in_data = (i_cur_state == st_first_byte) || (i_cur_state == st_second_byte);
	assign ack_end = (i_cur_state == st_ack_wait) && i_ack_open && i_stage_done;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			addr_q <= '0;
		end
		else if (ack_end)
		begin
			addr_q <= i_rnw ? RD_BASE_ADDR : WR_BASE_ADDR; // first byte follows the ack
		end
		else if (in_data && i_stage_done)
		begin
			addr_q <= addr_q + 12'd1;
		end
	end

	// the dummy byte reads from a fixed all-zero word
	assign o_regf_addr = (i_cur_state == st_dummy_byte) ? DUMMY_ADDR : addr_q;

	assign o_regf_rd_en = in_data && !i_rnw;   // write: fetch bytes to send
	assign o_regf_wr_en = in_data && i_rnw;    // read: store received bytes

endmodule

`default_nettype wire

//--- source/ddr_engine.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_engine
	import ddr_pkg::*;
#(
	parameter regf_addr_t   WR_BASE_ADDR = 12'd1,
	parameter regf_addr_t   RD_BASE_ADDR = 12'd10,
	parameter regf_addr_t   DUMMY_ADDR   = 12'd1000,
	parameter target_addr_t ADDR_OFFSET  = 7'd8      // first dynamic address
)
(
	input  wire              i_sys_clk,
	input  wire              i_sys_rst,
	input  wire              i_engine_en,
	input  wire xfer_cfg_s   i_xfer_cfg,
	input  wire phy_status_s i_phy_status,
	output wire phy_ctrl_s   o_phy_ctrl,
	output wire [7:0]        o_tx_special_data,
	output wire regf_addr_t  o_regf_addr,
	output wire              o_regf_rd_en,
	output wire              o_regf_wr_en,
	output wire              o_regf_abort,
	output wire err_type_e   o_regf_error_type,
	output wire              o_engine_done
);

	ddr_state_e cur_state;
	logic       ack_open;
	logic       stage_done;

	ddr_sequencer u_sequencer (
		.i_sys_clk         (i_sys_clk),
		.i_sys_rst         (i_sys_rst),
		.i_engine_en       (i_engine_en),
		.i_xfer_cfg        (i_xfer_cfg),
		.i_phy_status      (i_phy_status),
		.o_cur_state       (cur_state),
		.o_ack_open        (ack_open),
		.o_stage_done      (stage_done),
		.o_regf_abort      (o_regf_abort),
		.o_regf_error_type (o_regf_error_type),
		.o_engine_done     (o_engine_done)
	);

	ddr_mode_decode #(
		.ADDR_OFFSET (ADDR_OFFSET)
	) u_mode_decode (
		.i_cur_state       (cur_state),
		.i_ack_open        (ack_open),
		.i_xfer_cfg        (i_xfer_cfg),
		.o_phy_ctrl        (o_phy_ctrl),
		.o_tx_special_data (o_tx_special_data)
	);

	regf_addr_gen #(
		.WR_BASE_ADDR (WR_BASE_ADDR),
		.RD_BASE_ADDR (RD_BASE_ADDR),
		.DUMMY_ADDR   (DUMMY_ADDR)
	) u_regf_addr_gen (
		.i_sys_clk    (i_sys_clk),
		.i_sys_rst    (i_sys_rst),
		.i_cur_state  (cur_state),
		.i_ack_open   (ack_open),
		.i_stage_done (stage_done),
		.i_rnw        (i_xfer_cfg.rnw),
		.o_regf_addr  (o_regf_addr),
		.o_regf_rd_en (o_regf_rd_en),
		.o_regf_wr_en (o_regf_wr_en)
	);

endmodule

`default_nettype wire

//--- tests/ddr_engine_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_engine_assertions
	import ddr_pkg::*;
(
	input wire             i_sys_clk,
	input wire             i_sys_rst,
	input wire phy_ctrl_s  i_phy_ctrl,
	input wire ddr_state_e i_cur_state,
	input wire             i_rnw,
	input wire             i_engine_done,
	input wire             i_regf_abort,
	input wire             i_regf_rd_en,
	input wire             i_regf_wr_en
);

	// one side of the bus at a time, ack wait of a write aside
	tx_rx_exclusive: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		!(i_phy_ctrl.tx_en && i_phy_ctrl.rx_en) || (i_cur_state == st_ack_wait && !i_rnw))
		else $error("tx_en and rx_en high together");

	done_one_cycle: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		i_engine_done |=> !i_engine_done)
		else $error("o_engine_done longer than one cycle");

	abort_one_cycle: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		i_regf_abort |=> !i_regf_abort)
		else $error("o_regf_abort longer than one cycle");

	strobes_exclusive: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		!(i_regf_rd_en && i_regf_wr_en))
		else $error("regf rd_en and wr_en high together");

endmodule

bind ddr_engine ddr_engine_assertions u_assertions (
	.i_sys_clk     (i_sys_clk),
	.i_sys_rst     (i_sys_rst),
	.i_phy_ctrl    (o_phy_ctrl),
	.i_cur_state   (cur_state),
	.i_rnw         (i_xfer_cfg.rnw),
	.i_engine_done (o_engine_done),
	.i_regf_abort  (o_regf_abort),
	.i_regf_rd_en  (o_regf_rd_en),
	.i_regf_wr_en  (o_regf_wr_en)
);

`default_nettype wire

//--- tests/tb_ddr_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_engine
	import ddr_pkg::*;
();

	localparam int CLK_PERIOD       = 40;
	localparam int RESET_CYCLES     = 8;
	localparam int NUM_TESTS        = 7;
	localparam int MAX_STAGES       = 24;   // longest transfer in stages
	localparam int MAX_STAGE_CYCLES = 6;    // sample, up to 3 delay, done, turnaround
	localparam int MARGIN           = 4;
	localparam int XFER_LIMIT       = MAX_STAGES * MAX_STAGE_CYCLES * 2;
	localparam int WATCHDOG_CYCLES  = RESET_CYCLES
		+ NUM_TESTS * (MAX_STAGES * MAX_STAGE_CYCLES + 4) * MARGIN;
	localparam int ADDR_OFFSET      = 8;    // default dynamic address base

	logic        sys_clk;
	logic        sys_rst;
	logic        engine_en;
	xfer_cfg_s   xfer_cfg;
	phy_status_s phy_status = '0;          // owned by the phy model
	phy_ctrl_s   phy_ctrl;
	logic [7:0]  tx_special_data;
	regf_addr_t  regf_addr;
	logic        regf_rd_en;
	logic        regf_wr_en;
	logic        regf_abort;
	err_type_e   error_type;
	logic        engine_done;

	// script of the current transfer as the test sets it
	int   frame_len;                       // frame counter length in bytes
	int   tgt_bytes;                       // bytes the target sends on a read
	logic nack_ack;
	logic abort_req;
	logic crc_bad;

	// phy model log that each new transfer clears
	tx_mode_e   tx_log[$];
	rx_mode_e   rx_log[$];
	regf_addr_t addr_log[$];
	logic [1:0] strobe_log[$];             // {wr_en, rd_en} per data byte
	logic [7:0] special_log[$];

	int     done_cnt  = 0;
	int     abort_cnt = 0;
	int     errors;
	int     tests_run;
	int     tests_failed;
	integer seed;

	ddr_engine u_dut (
		.i_sys_clk         (sys_clk),
		.i_sys_rst         (sys_rst),
		.i_engine_en       (engine_en),
		.i_xfer_cfg        (xfer_cfg),
		.i_phy_status      (phy_status),
		.o_phy_ctrl        (phy_ctrl),
		.o_tx_special_data (tx_special_data),
		.o_regf_addr       (regf_addr),
		.o_regf_rd_en      (regf_rd_en),
		.o_regf_wr_en      (regf_wr_en),
		.o_regf_abort      (regf_abort),
		.o_regf_error_type (error_type),
		.o_engine_done     (engine_done)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	always @(posedge sys_clk)
	begin
		if (engine_done)
			done_cnt++;
		if (regf_abort)
			abort_cnt++;
	end

	// answers every enabled stage after a random delay
	always
	begin : phy_model
		int          dly;
		int          byte_cnt;
		logic        ack_seen;
		logic        data_ended;
		phy_status_s resp;
		@(posedge sys_clk);
		#1;
		if (engine_en)
		begin
			tx_log.delete();       // new transfer
			rx_log.delete();
			addr_log.delete();
			strobe_log.delete();
			special_log.delete();
			byte_cnt   = 0;
			ack_seen   = 1'b0;
			data_ended = 1'b0;
		end
		if (phy_ctrl.tx_en || phy_ctrl.rx_en)
		begin
			resp         = '0;
			resp.tx_done = phy_ctrl.tx_en;
			resp.rx_done = !phy_ctrl.tx_en;
			if (phy_ctrl.tx_en)
				tx_log.push_back(phy_ctrl.tx_mode);
			if (phy_ctrl.rx_en)
				rx_log.push_back(phy_ctrl.rx_mode);
			if (phy_ctrl.tx_en && phy_ctrl.tx_mode == txm_address)
				special_log.push_back(tx_special_data);
			if ((phy_ctrl.tx_en && phy_ctrl.tx_mode == txm_byte)
				|| (phy_ctrl.rx_en && phy_ctrl.rx_mode == rxm_byte))
			begin
				byte_cnt++;
				addr_log.push_back(regf_addr);
				strobe_log.push_back({regf_wr_en, regf_rd_en});
			end
			resp.frm_last = (byte_cnt >= frame_len);
			if (!phy_ctrl.tx_en && phy_ctrl.rx_mode == rxm_preamble)
			begin
				if (!ack_seen)
				begin
					resp.rx_pre = nack_ack;        // high is a nack
					ack_seen    = 1'b1;
				end
				else if (!xfer_cfg.rnw)
					resp.rx_pre = !abort_req;      // write abort bit
				else if (!data_ended && byte_cnt < tgt_bytes)
					resp.rx_pre = 1'b1;            // target goes on
				else if (!data_ended)
					data_ended = 1'b1;             // target stops with rx_pre low
				else
					resp.rx_pre = 1'b1;            // crc preamble
			end
			if (phy_ctrl.rx_en && phy_ctrl.rx_mode == rxm_crc_chk)
				resp.rx_error = crc_bad;
			dly = $unsigned($random(seed)) % 4;
			#1;
			repeat (dly) @(posedge sys_clk);
			if (dly != 0)
				#2;
			phy_status = resp;
			@(posedge sys_clk);
			#2;
			phy_status = '0;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic close_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("%s: passed", name);
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	// starts one transfer and waits for the done pulse
	task automatic run_xfer(input logic rnw, input logic toc, input logic short_err,
		input int dev, input int flen, input int tbytes, input logic nack,
		input logic abort, input logic crc);
		int cycles;
		xfer_cfg.rnw            = rnw;
		xfer_cfg.toc            = toc;
		xfer_cfg.short_read_err = short_err;
		xfer_cfg.dev_index      = 5'(dev);
		frame_len = flen;
		tgt_bytes = tbytes;
		nack_ack  = nack;
		abort_req = abort;
		crc_bad   = crc;
		engine_en = 1'b1;
		@(posedge sys_clk);
		#2;
		engine_en = 1'b0;
		cycles    = 0;
		while (!engine_done && cycles < XFER_LIMIT)
		begin
			@(posedge sys_clk);
			#1;
			cycles++;
		end
		if (!engine_done)
		begin
			$display("transfer did not finish within %0d cycles", XFER_LIMIT);
			errors++;
		end
		@(posedge sys_clk);                // let the monitor count the pulse
		#2;
	endtask

	task automatic reset_values();
		int e0;
		e0 = errors;
		check_val("tx_en", 32'(phy_ctrl.tx_en), 32'd0);
		check_val("rx_en", 32'(phy_ctrl.rx_en), 32'd0);
		check_val("frmcnt_en", 32'(phy_ctrl.frmcnt_en), 32'd0);
		check_val("bitcnt_en", 32'(phy_ctrl.bitcnt_en), 32'd0);
		check_val("bitcnt_rst", 32'(phy_ctrl.bitcnt_rst), 32'd0);
		check_val("o_regf_rd_en", 32'(regf_rd_en), 32'd0);
		check_val("o_regf_wr_en", 32'(regf_wr_en), 32'd0);
		check_val("o_regf_abort", 32'(regf_abort), 32'd0);
		check_val("o_engine_done", 32'(engine_done), 32'd0);
		check_val("o_regf_error_type", 32'(error_type), 32'(err_success));
		check_val("o_regf_addr", 32'(regf_addr), 32'd0);
		close_test("reset_values", e0);
	endtask

	task automatic two_byte_write();
		tx_mode_e exp_tx [14] = '{txm_special_pre, txm_zero, txm_seven_zeros,
			txm_address, txm_parity, txm_one, txm_byte, txm_byte, txm_parity,
			txm_zero, txm_one, txm_crc_token, txm_crc_value, txm_exit};
		int e0;
		int d0;
		e0 = errors;
		d0 = done_cnt;
		run_xfer(1'b0, 1'b1, 1'b0, 5, 2, 0, 1'b0, 1'b0, 1'b0);
		check_val("tx_mode count", 32'(tx_log.size()), 32'd14);
		for (int i = 0; i < 14 && i < tx_log.size(); i++)
			check_val($sformatf("tx_mode[%0d]", i), 32'(tx_log[i]), 32'(exp_tx[i]));
		check_val("rx_mode count", 32'(rx_log.size()), 32'd1);
		check_val("o_tx_special_data", 32'(special_log.size() > 0 ? special_log[0] : 8'hff),
			32'(5 + ADDR_OFFSET));
		check_val("data byte count", 32'(addr_log.size()), 32'd2);
		if (addr_log.size() == 2)
		begin
			check_val("o_regf_addr", 32'(addr_log[0]), 32'd1);
			check_val("o_regf_addr", 32'(addr_log[1]), 32'd2);
			check_val("rd/wr strobes", 32'(strobe_log[0]), 32'b01);
			check_val("rd/wr strobes", 32'(strobe_log[1]), 32'b01);
		end
		check_val("o_engine_done pulses", 32'(done_cnt - d0), 32'd1);
		check_val("o_regf_error_type", 32'(error_type), 32'(err_success));
		close_test("two_byte_write", e0);
	endtask

	task automatic nack_write();
		int e0;
		int d0;
		e0 = errors;
		d0 = done_cnt;
		run_xfer(1'b0, 1'b0, 1'b0, 2, 2, 0, 1'b1, 1'b0, 1'b0);
		check_val("o_regf_error_type", 32'(error_type), 32'(err_nack));
		check_val("rx_mode count", 32'(rx_log.size()), 32'd2);
		if (rx_log.size() == 2)
			check_val("rx_mode[1]", 32'(rx_log[1]), 32'(rxm_error));
		if (tx_log.size() > 0)
			check_val("last tx_mode", 32'(tx_log[tx_log.size() - 1]), 32'(txm_restart));
		check_val("data byte count", 32'(addr_log.size()), 32'd0);  // no data after a nack
		check_val("o_engine_done pulses", 32'(done_cnt - d0), 32'd1);
		close_test("nack_write", e0);
	endtask

	task automatic one_byte_write();
		int e0;
		e0 = errors;
		run_xfer(1'b0, 1'b1, 1'b0, 0, 1, 0, 1'b0, 1'b0, 1'b0);
		check_val("data byte count", 32'(addr_log.size()), 32'd2);
		if (addr_log.size() == 2)
		begin
			check_val("o_regf_addr", 32'(addr_log[0]), 32'd1);
			check_val("o_regf_addr", 32'(addr_log[1]), 32'd1000);  // dummy fill
			check_val("rd/wr strobes", 32'(strobe_log[1]), 32'b00);
		end
		check_val("o_regf_error_type", 32'(error_type), 32'(err_success));
		close_test("one_byte_write", e0);
	endtask

	task automatic short_read();
		int e0;
		e0 = errors;
		run_xfer(1'b1, 1'b1, 1'b1, 3, 4, 2, 1'b0, 1'b0, 1'b0);
		check_val("o_regf_error_type", 32'(error_type), 32'(err_short_read));
		check_val("data byte count", 32'(addr_log.size()), 32'd2);
		if (addr_log.size() == 2)
		begin
			check_val("o_regf_addr", 32'(addr_log[0]), 32'd10);
			check_val("o_regf_addr", 32'(addr_log[1]), 32'd11);
			check_val("rd/wr strobes", 32'(strobe_log[0]), 32'b10);
		end
		if (rx_log.size() > 0)
			check_val("last rx_mode", 32'(rx_log[rx_log.size() - 1]), 32'(rxm_error));
		close_test("short_read", e0);
	endtask

	task automatic crc_error_read();
		int e0;
		int d0;
		e0 = errors;
		d0 = done_cnt;
		run_xfer(1'b1, 1'b1, 1'b0, 1, 2, 2, 1'b0, 1'b0, 1'b1);
		check_val("o_regf_error_type", 32'(error_type), 32'(err_crc));
		if (rx_log.size() > 1)
			check_val("rx_mode before error", 32'(rx_log[rx_log.size() - 2]),
				32'(rxm_crc_chk));
		if (tx_log.size() > 0)
			check_val("last tx_mode", 32'(tx_log[tx_log.size() - 1]), 32'(txm_exit));
		check_val("o_engine_done pulses", 32'(done_cnt - d0), 32'd1);
		close_test("crc_error_read", e0);
	endtask

	task automatic target_abort_write();
		int e0;
		int a0;
		e0 = errors;
		a0 = abort_cnt;
		run_xfer(1'b0, 1'b1, 1'b0, 4, 4, 0, 1'b0, 1'b1, 1'b0);
		check_val("o_regf_abort pulses", 32'(abort_cnt - a0), 32'd1);
		check_val("o_regf_error_type", 32'(error_type), 32'(err_bus_aborted));
		check_val("data byte count", 32'(addr_log.size()), 32'd2);
		close_test("target_abort_write", e0);
	endtask

	initial
	begin
		sys_clk      = 1'b0;
		sys_rst      = 1'b0;
		engine_en    = 1'b0;
		xfer_cfg     = '0;
		frame_len    = 0;
		tgt_bytes    = 0;
		nack_ack     = 1'b0;
		abort_req    = 1'b0;
		crc_bad      = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		seed         = 32'h74744de1;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#2;
		sys_rst = 1'b1;
		@(posedge sys_clk);
		#2;
		reset_values();
		two_byte_write();
		nack_write();
		one_byte_write();
		short_read();
		crc_error_read();
		target_abort_write();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// hard limit on the whole run
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the engine stopped answering");
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
common/ddr_pkg.sv
source/ddr_sequencer.sv
source/ddr_mode_decode.sv
source/regf_addr_gen.sv
source/ddr_engine.sv
tests/ddr_engine_assertions.sv
tests/tb_ddr_engine.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ddr_engine -f vlog.f -o tb_ddr_engine \
	&& ./obj_dir/tb_ddr_engine 2>&1 | tee sim.log \
	|| { echo "simulation build or run failed"; exit 1; }

grep -qF '** FAIL **' sim.log && { echo "simulation reported failure"; exit 1; } || exit 0
